// File: hdl/io_strobe.sv
`timescale 1ns/1ps

module io_strobe import zx_types_pkg::*;
(
	input  logic      zclk,
	input  logic      rst_n,
	input  io_cycle_t io,
	output logic      port_wr,
	output logic      port_rd
);

	logic wr_cyc;
	logic rd_cyc;
	logic iowr_reg;   // level seen on the previous edge
	logic iord_reg;

	assign wr_cyc = ~(io.iorq_n | io.wr_n);
	assign rd_cyc = ~(io.iorq_n | io.rd_n);

	// pulse only on the first edge of an access
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_reg <= 1'b0;
			iord_reg <= 1'b0;
			port_wr  <= 1'b0;
			port_rd  <= 1'b0;
		end
		else
		begin
			iowr_reg <= wr_cyc;
			iord_reg <= rd_cyc;
			port_wr  <= wr_cyc & ~iowr_reg;
			port_rd  <= rd_cyc & ~iord_reg;
		end
	end

endmodule

// File: hdl/paging_regs.sv
`timescale 1ns/1ps

module paging_regs import port_map_pkg::*, zx_types_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  io_cycle_t  io,
	input  wr_sel_t    sel,
	input  logic [1:0] rstrom,
	output page_cfg_t  page
);

	logic [7:0] p7ffd_r;
	logic [7:0] peff7_r;
	logic       rom_r;
	logic       rst_s1;
	logic       rst_s2;
	logic       lock1m;
	logic       wr_7ffd;

	assign lock1m  = peff7_r[pe_lock1m_bit];
	assign wr_7ffd = sel.p7ffd && !(p7ffd_r[p7_lock48_bit] && lock1m);   // 48k lock

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_r <= 8'h00;
			peff7_r <= 8'h00;
		end
		else
		begin
			if (wr_7ffd)
				p7ffd_r <= io.din;
			if (sel.eff7)
				peff7_r <= io.din;
		end
	end

	// reset flag held two edges past reset release
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rst_s1 <= 1'b1;
			rst_s2 <= 1'b1;
		end
		else
		begin
			rst_s1 <= 1'b0;
			rst_s2 <= rst_s1;
		end
	end

	always_ff @(posedge zclk)
	begin
		if (rst_s2)
			rom_r <= rstrom[0];   // boot rom choice
		else if (wr_7ffd)
			rom_r <= io.din[4];
	end

	always_comb
	begin
		page.p7ffd = {(lock1m ? 3'b000 : p7ffd_r[7:5]), rom_r, p7ffd_r[3:0]};
		if (lock1m)
			page.peff7 = {peff7_r[7], 1'b0, peff7_r[5], peff7_r[4], 3'b000, peff7_r[0]};
		else
			page.peff7 = peff7_r;
		page.pent1m_page   = {p7ffd_r[7:5], p7ffd_r[2:0]};
		page.pent1m_rom    = p7ffd_r[4];
		page.pent1m_1m_on  = ~peff7_r[pe_lock1m_bit];
		page.pent1m_ram0_0 = peff7_r[3];
	end

endmodule

// File: hdl/port_decode.sv
`timescale 1ns/1ps

module port_decode import port_map_pkg::*, zx_types_pkg::*;
(
	input  io_cycle_t  io,
	input  logic       dos,
	input  in_lines_t  lines,
	input  logic       port_wr,
	input  logic       port_rd,
	output logic       porthit,
	output logic       dataout,
	output logic [7:0] dout,
	output logic       ay_bc1,
	output logic       ay_bdir,
	output wr_sel_t    sel
);

	logic [7:0] loa;
	logic       external_port;
	logic       pre_bc1;
	logic       pre_bdir;

	assign loa = io.addr[7:0];

	////////////////////////////////////////
	// hit and read data
	////////////////////////////////////////

	always_comb
	begin
		porthit = (loa == port_fe) || (loa == port_fd) ||
			(loa == port_kmouse) || (loa == port_cvx) ||
			((loa == port_kjoy) && !dos) ||
			((loa == port_f7) && !dos);
	end

	assign external_port = (loa == port_fd) && (io.addr[15:14] == 2'b11);   // ay reads from the chip

	assign dataout = porthit & ~io.iorq_n & ~io.rd_n & ~external_port;

	always_comb
	begin
		case (loa)
			port_fe:
				dout = {1'b1, lines.tape_read, 1'b0, lines.keys};
			port_kjoy:
			begin
				if (!dos)
					dout = {3'b000, lines.kjoy};
				else
					dout = 8'hFF;   // vg93 space in dos, not ours
			end
			port_kmouse:
				dout = lines.mouse;
			default:
				dout = 8'hFF;   // f7 lands here as well
		endcase
	end

	////////////////////////////////////////
	// ay bus control
	////////////////////////////////////////

	always_comb
	begin
		pre_bc1  = 1'b0;
		pre_bdir = 1'b0;
		if (loa == port_fd)
		begin
			if (io.addr[15:14] == 2'b11)   // fffd, register select / read
			begin
				pre_bc1  = 1'b1;
				pre_bdir = 1'b1;
			end
			else if (io.addr[15:14] == 2'b10)   // bffd, data write
				pre_bdir = 1'b1;
		end
	end

	assign ay_bc1  = pre_bc1 & ~io.iorq_n & (~io.rd_n | ~io.wr_n);
	assign ay_bdir = pre_bdir & ~io.iorq_n & ~io.wr_n;

	////////////////////////////////////////
	// write selects
	////////////////////////////////////////

	always_comb
	begin
		sel.fe    = port_wr && (loa == port_fe);
		sel.p7ffd = port_wr && (loa == port_fd) && !io.addr[15];
		sel.eff7  = port_wr && (loa == port_f7) && !io.addr[12] && !dos;
		sel.cvx   = port_wr && (loa == port_cvx);
		sel.xt    = port_wr && (loa == port_xt);
	end

endmodule

// File: hdl/port_map_pkg.sv
package port_map_pkg;

	////////////////////////////////////////
	// low address byte of each port
	////////////////////////////////////////

	localparam logic [7:0] port_fe     = 8'hFE;   // keys, tape, border, beeper
	localparam logic [7:0] port_fd     = 8'hFD;   // 7ffd paging, ay at fffd/bffd
	localparam logic [7:0] port_f7     = 8'hF7;   // eff7 paging
	localparam logic [7:0] port_cvx    = 8'hFB;   // covox
	localparam logic [7:0] port_xt     = 8'h6F;   // xt config, index on a[15:8]
	localparam logic [7:0] port_kjoy   = 8'h1F;   // kempston joystick
	localparam logic [7:0] port_kmouse = 8'hDF;   // kempston mouse

	////////////////////////////////////////
	// xt register indices
	////////////////////////////////////////

	localparam logic [7:0] xt_border  = 8'h00;
	localparam logic [7:0] xt_vconfig = 8'h08;
	localparam logic [7:0] xt_fpage   = 8'h09;
	localparam logic [7:0] xt_faddr   = 8'h0A;
	localparam logic [7:0] xt_tpage   = 8'h0B;
	localparam logic [7:0] xt_tgpage0 = 8'h0C;
	localparam logic [7:0] xt_tgpage1 = 8'h0D;

	// 9-bit timing values, low byte then msb
	localparam logic [7:0] xt_hs0l    = 8'h10;
	localparam logic [7:0] xt_hs0h    = 8'h11;
	localparam logic [7:0] xt_vs0l    = 8'h12;
	localparam logic [7:0] xt_vs0h    = 8'h13;
	localparam logic [7:0] xt_hs1l    = 8'h14;
	localparam logic [7:0] xt_hs1h    = 8'h15;
	localparam logic [7:0] xt_vs1l    = 8'h16;
	localparam logic [7:0] xt_vs1h    = 8'h17;

	////////////////////////////////////////
	// bits inside the paging bytes
	////////////////////////////////////////

	// 7ffd: 2..0 page, 3 screen, 4 rom, 5 lock48, 7..6 high page
	localparam int p7_lock48_bit = 5;

	// eff7: set means the 1 MB extension is locked off
	localparam int pe_lock1m_bit = 2;

endpackage

// File: hdl/xt_regs.sv
`timescale 1ns/1ps

module xt_regs import port_map_pkg::*, zx_types_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  io_cycle_t  io,
	input  wr_sel_t    sel,
	output logic [5:0] border,
	output logic [7:0] cvx,
	output vid_cfg_t   vid
);

	logic [7:0] xt_addr;
	logic [7:0] din;

	assign xt_addr = io.addr[15:8];
	assign din     = io.din;

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border  <= 6'd0;
			cvx     <= 8'd0;
			vid     <= '0;
			vid.fwd <= 1'b1;
		end
		else
		begin
			////////////////////////////////////////
			// fe border and beeper, fb covox
			////////////////////////////////////////
			if (sel.fe)
			begin
				cvx    <= {din[4], {7{din[3]}}};   // ear on top, mic spread below
				border <= {din[1], 1'b0, din[2], 1'b0, din[0], 1'b0};
			end

			if (sel.cvx)
				cvx <= din;

			////////////////////////////////////////
			// xt register file
			////////////////////////////////////////
			if (sel.xt)
			begin
				case (xt_addr)
					xt_border:
						border <= din[5:0];
					xt_vconfig:
						vid.vcfg <= din;
					xt_fpage:
						vid.fp <= din;
					xt_faddr:
					begin
						vid.fa  <= din[1:0];
						vid.fwd <= din[7];
					end
					xt_tpage:
						vid.tp <= din;
					xt_tgpage0:
						vid.tgp0 <= din[5:0];
					xt_tgpage1:
						vid.tgp1 <= din[5:0];
					xt_hs0l:
						vid.hs0[7:0] <= din;
					xt_hs0h:
						vid.hs0[8] <= din[0];
					xt_vs0l:
						vid.vs0[7:0] <= din;
					xt_vs0h:
						vid.vs0[8] <= din[0];
					xt_hs1l:
						vid.hs1[7:0] <= din;
					xt_hs1h:
						vid.hs1[8] <= din[0];
					xt_vs1l:
						vid.vs1[7:0] <= din;
					xt_vs1h:
						vid.vs1[8] <= din[0];
					default:
						;   // unused index, ignored
				endcase
			end
		end
	end

endmodule

// File: hdl/zports_top.sv
`timescale 1ns/1ps

module zports_top import zx_types_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  io_cycle_t  io,
	input  logic       dos,
	input  in_lines_t  lines,
	input  logic [1:0] rstrom,
	output logic [7:0] dout,
	output logic       dataout,
	output logic       porthit,
	output logic       ay_bc1,
	output logic       ay_bdir,
	output logic [5:0] border,
	output logic [7:0] cvx,
	output page_cfg_t  page,
	output vid_cfg_t   vid
);

	logic    port_wr;
	logic    port_rd;
	wr_sel_t sel;

	io_strobe strobe_i (
		.zclk    (zclk),
		.rst_n   (rst_n),
		.io      (io),
		.port_wr (port_wr),
		.port_rd (port_rd)
	);

	port_decode decode_i (
		.io      (io),
		.dos     (dos),
		.lines   (lines),
		.port_wr (port_wr),
		.port_rd (port_rd),
		.porthit (porthit),
		.dataout (dataout),
		.dout    (dout),
		.ay_bc1  (ay_bc1),
		.ay_bdir (ay_bdir),
		.sel     (sel)
	);

	paging_regs paging_i (
		.zclk   (zclk),
		.rst_n  (rst_n),
		.io     (io),
		.sel    (sel),
		.rstrom (rstrom),
		.page   (page)
	);

	xt_regs xt_i (
		.zclk   (zclk),
		.rst_n  (rst_n),
		.io     (io),
		.sel    (sel),
		.border (border),
		.cvx    (cvx),
		.vid    (vid)
	);

endmodule

// File: hdl/zx_types_pkg.sv
package zx_types_pkg;

	// z80 side of one i/o access
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  din;
		logic        iorq_n;
		logic        rd_n;
		logic        wr_n;
	} io_cycle_t;

	// one-cycle write selects
	typedef struct packed {
		logic fe;
		logic p7ffd;
		logic eff7;
		logic cvx;
		logic xt;
	} wr_sel_t;

	typedef struct packed {
		logic [7:0] p7ffd;          // rom bit from its own flop
		logic [7:0] peff7;          // masked under 1 MB lock
		logic [5:0] pent1m_page;
		logic       pent1m_rom;
		logic       pent1m_1m_on;
		logic       pent1m_ram0_0;
	} page_cfg_t;

	// xt video config
	typedef struct packed {
		logic [7:0] vcfg;
		logic [8:0] hs0;
		logic [8:0] hs1;
		logic [8:0] vs0;
		logic [8:0] vs1;
		logic [7:0] fp;
		logic [1:0] fa;
		logic       fwd;
		logic [7:0] tp;
		logic [5:0] tgp0;
		logic [5:0] tgp1;
	} vid_cfg_t;

	typedef struct packed {
		logic [4:0] keys;
		logic [7:0] mouse;
		logic [4:0] kjoy;
		logic       tape_read;
	} in_lines_t;

endpackage

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_zports \
		-f vlog.f -o sim_zports &&
	./obj_dir/sim_zports | tee /dev/stderr | grep -q "Test completed successfully" &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }

// File: tb/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// each row holds kind, compared output, addr, data, dos, random flag and expected value
typedef enum logic [1:0] {op_read, op_write, op_check} op_t;

typedef enum logic [3:0]
{
	t_none, t_bus, t_ay, t_border, t_cvx, t_p7ffd, t_peff7,
	t_pg1m, t_pflags, t_vcfg, t_fwd, t_fa, t_hs0, t_vs1, t_tgp0
} tgt_t;

typedef struct packed {
	op_t         kind;
	tgt_t        tgt;
	logic [15:0] addr;
	logic [7:0]  data;
	logic        dos;
	logic        rnd;   // random lines on reads and random data on writes
	logic [15:0] exp;
} vec_t;

// bus reads expect {ay_bdir, ay_bc1, dataout, porthit, dout}
// random checks use exp as a mask on the last byte written
localparam int num_rows = 60;

localparam vec_t table_rows [num_rows] = '{
	'{op_check, t_border, 16'h0000, 8'h00, 1'b0, 1'b0, 16'h0000},   // reset values
	'{op_check, t_cvx,    16'h0000, 8'h00, 1'b0, 1'b0, 16'h0000},
	'{op_check, t_vcfg,   16'h0000, 8'h00, 1'b0, 1'b0, 16'h0000},
	'{op_check, t_fwd,    16'h0000, 8'h00, 1'b0, 1'b0, 16'h0001},
	'{op_check, t_p7ffd,  16'h0000, 8'h00, 1'b0, 1'b0, 16'h0010},   // rom bit from rstrom
	'{op_check, t_peff7,  16'h0000, 8'h00, 1'b0, 1'b0, 16'h0000},
	'{op_check, t_pflags, 16'h0000, 8'h00, 1'b0, 1'b0, 16'h0002},
	'{op_check, t_hs0,    16'h0000, 8'h00, 1'b0, 1'b0, 16'h0000},
	'{op_read,  t_bus,    16'h00FE, 8'h00, 1'b0, 1'b1, 16'h0300},   // reads
	'{op_read,  t_bus,    16'hFADF, 8'h00, 1'b0, 1'b1, 16'h0300},
	'{op_read,  t_bus,    16'h001F, 8'h00, 1'b0, 1'b1, 16'h0300},
	'{op_read,  t_bus,    16'h001F, 8'h00, 1'b1, 1'b0, 16'h00FF},
	'{op_read,  t_bus,    16'h1255, 8'h00, 1'b0, 1'b0, 16'h00FF},
	'{op_read,  t_bus,    16'h00F7, 8'h00, 1'b0, 1'b0, 16'h03FF},
	'{op_read,  t_bus,    16'hFFFD, 8'h00, 1'b0, 1'b0, 16'h05FF},
	'{op_write, t_ay,     16'hBFFD, 8'h3C, 1'b0, 1'b0, 16'h0001},   // ay writes
	'{op_write, t_ay,     16'hFFFD, 8'h0E, 1'b0, 1'b0, 16'h0003},
	'{op_write, t_none,   16'h7FFD, 8'hC3, 1'b0, 1'b0, 16'h0000},   // paging
	'{op_check, t_p7ffd,  16'h0000, 8'h00, 1'b0, 1'b0, 16'h00C3},
	'{op_check, t_pg1m,   16'h0000, 8'h00, 1'b0, 1'b0, 16'h0033},
	'{op_write, t_none,   16'hEFF7, 8'hFF, 1'b0, 1'b0, 16'h0000},
	'{op_check, t_p7ffd,  16'h0000, 8'h00, 1'b0, 1'b0, 16'h0003},
	'{op_check, t_peff7,  16'h0000, 8'h00, 1'b0, 1'b0, 16'h00B1},
	'{op_check, t_pflags, 16'h0000, 8'h00, 1'b0, 1'b0, 16'h0001},
	'{op_write, t_none,   16'h7FFD, 8'h35, 1'b0, 1'b0, 16'h0000},
	'{op_check, t_p7ffd,  16'h0000, 8'h00, 1'b0, 1'b0, 16'h0015},
	'{op_check, t_pflags, 16'h0000, 8'h00, 1'b0, 1'b0, 16'h0005},
	'{op_write, t_none,   16'h7FFD, 8'h07, 1'b0, 1'b0, 16'h0000},   // locked out
	'{op_check, t_p7ffd,  16'h0000, 8'h00, 1'b0, 1'b0, 16'h0015},
	'{op_check, t_pg1m,   16'h0000, 8'h00, 1'b0, 1'b0, 16'h000D},
	'{op_write, t_none,   16'hEFF7, 8'h00, 1'b1, 1'b0, 16'h0000},   // shadow on
	'{op_check, t_peff7,  16'h0000, 8'h00, 1'b0, 1'b0, 16'h00B1},
	'{op_write, t_none,   16'h00FE, 8'h17, 1'b0, 1'b0, 16'h0000},   // border, beeper, covox
	'{op_check, t_border, 16'h0000, 8'h00, 1'b0, 1'b0, 16'h002A},
	'{op_check, t_cvx,    16'h0000, 8'h00, 1'b0, 1'b0, 16'h0080},
	'{op_write, t_none,   16'h00FE, 8'h0A, 1'b0, 1'b0, 16'h0000},
	'{op_check, t_border, 16'h0000, 8'h00, 1'b0, 1'b0, 16'h0020},
	'{op_check, t_cvx,    16'h0000, 8'h00, 1'b0, 1'b0, 16'h007F},
	'{op_write, t_none,   16'h00FB, 8'h00, 1'b0, 1'b1, 16'h0000},
	'{op_check, t_cvx,    16'h0000, 8'h00, 1'b0, 1'b1, 16'h00FF},
	'{op_write, t_none,   16'h006F, 8'h00, 1'b0, 1'b1, 16'h0000},
	'{op_check, t_border, 16'h0000, 8'h00, 1'b0, 1'b1, 16'h003F},
	'{op_write, t_none,   16'h106F, 8'hA5, 1'b0, 1'b0, 16'h0000},   // xt registers
	'{op_write, t_none,   16'h116F, 8'h01, 1'b0, 1'b0, 16'h0000},
	'{op_check, t_hs0,    16'h0000, 8'h00, 1'b0, 1'b0, 16'h01A5},
	'{op_write, t_none,   16'h166F, 8'h3C, 1'b0, 1'b0, 16'h0000},
	'{op_write, t_none,   16'h176F, 8'hFE, 1'b0, 1'b0, 16'h0000},
	'{op_check, t_vs1,    16'h0000, 8'h00, 1'b0, 1'b0, 16'h003C},
	'{op_write, t_none,   16'h0A6F, 8'h7E, 1'b0, 1'b0, 16'h0000},
	'{op_check, t_fa,     16'h0000, 8'h00, 1'b0, 1'b0, 16'h0002},
	'{op_check, t_fwd,    16'h0000, 8'h00, 1'b0, 1'b0, 16'h0000},
	'{op_write, t_none,   16'h0C6F, 8'hFF, 1'b0, 1'b0, 16'h0000},
	'{op_check, t_tgp0,   16'h0000, 8'h00, 1'b0, 1'b0, 16'h003F},
	'{op_write, t_none,   16'h086F, 8'h5A, 1'b0, 1'b0, 16'h0000},
	'{op_check, t_vcfg,   16'h0000, 8'h00, 1'b0, 1'b0, 16'h005A},
	'{op_write, t_none,   16'h0E6F, 8'hC0, 1'b0, 1'b0, 16'h0000},   // unused index
	'{op_check, t_vcfg,   16'h0000, 8'h00, 1'b0, 1'b0, 16'h005A},
	'{op_check, t_tgp0,   16'h0000, 8'h00, 1'b0, 1'b0, 16'h003F},
	'{op_check, t_hs0,    16'h0000, 8'h00, 1'b0, 1'b0, 16'h01A5},
	'{op_check, t_fa,     16'h0000, 8'h00, 1'b0, 1'b0, 16'h0002}
};

`endif

// File: tb/tb_zports.sv
`timescale 1ns/1ps

module tb_zports import port_map_pkg::*, zx_types_pkg::*;
();

	logic       zclk;
	logic       rst_n;
	io_cycle_t  io;
	logic       dos;
	in_lines_t  lines;
	logic [1:0] rstrom;
	logic [7:0] dout;
	logic       dataout;
	logic       porthit;
	logic       ay_bc1;
	logic       ay_bdir;
	logic [5:0] border;
	logic [7:0] cvx;
	page_cfg_t  page;
	vid_cfg_t   vid;

	localparam io_cycle_t io_idle = '{addr: 16'h0000, din: 8'h00,
		iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};

	`include "tb_vectors.svh"

	zports_top dut_i (.*);

	initial
	begin
		zclk = 1'b0;
		forever #2 zclk = ~zclk;
	end

	task automatic abort_run(string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(string name, logic [15:0] got, logic [15:0] exp);
		assert (got === exp)
		else
			abort_run($sformatf("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp));
	endtask

	// port read values as the address map defines them
	function automatic logic [7:0] expected_dout(logic [7:0] lo, logic d, in_lines_t l);
		case (lo)
			port_fe:     return {1'b1, l.tape_read, 1'b0, l.keys};
			port_kmouse: return l.mouse;
			port_kjoy:   return d ? 8'hFF : {3'b000, l.kjoy};
			default:     return 8'hFF;
		endcase
	endfunction

	function automatic logic [15:0] observe(tgt_t t);
		case (t)
			t_ay:     return {14'd0, ay_bc1, ay_bdir};
			t_border: return {10'd0, border};
			t_cvx:    return {8'd0, cvx};
			t_p7ffd:  return {8'd0, page.p7ffd};
			t_peff7:  return {8'd0, page.peff7};
			t_pg1m:   return {10'd0, page.pent1m_page};
			t_pflags: return {13'd0, page.pent1m_rom, page.pent1m_1m_on, page.pent1m_ram0_0};
			t_vcfg:   return {8'd0, vid.vcfg};
			t_fwd:    return {15'd0, vid.fwd};
			t_fa:     return {14'd0, vid.fa};
			t_hs0:    return {7'd0, vid.hs0};
			t_vs1:    return {7'd0, vid.vs1};
			t_tgp0:   return {10'd0, vid.tgp0};
			default:  return 16'd0;
		endcase
	endfunction

	function automatic string signal_name(tgt_t t);
		case (t)
			t_ay:     return "{ay_bc1, ay_bdir}";
			t_border: return "border";
			t_cvx:    return "cvx";
			t_p7ffd:  return "page.p7ffd";
			t_peff7:  return "page.peff7";
			t_pg1m:   return "page.pent1m_page";
			t_pflags: return "{page.pent1m_rom, page.pent1m_1m_on, page.pent1m_ram0_0}";
			t_vcfg:   return "vid.vcfg";
			t_fwd:    return "vid.fwd";
			t_fa:     return "vid.fa";
			t_hs0:    return "vid.hs0";
			t_vs1:    return "vid.vs1";
			t_tgp0:   return "vid.tgp0";
			default:  return "none";
		endcase
	endfunction

	initial
	begin
		vec_t        row;
		in_lines_t   cur_lines;
		logic [31:0] rnd_word;
		logic [7:0]  wr_data;
		logic [7:0]  last_data;
		logic [7:0]  exp_dout;
		int          strobe_count;
		int          i;
		int          c;

		rnd_word  = $urandom(32'h61bb);
		rst_n     = 1'b0;
		io        = io_idle;
		dos       = 1'b0;
		cur_lines = '0;
		lines     = cur_lines;
		rstrom    = 2'b01;   // boot rom 1
		last_data = 8'h00;

		for (c = 0; c < 2; c++)
			@(posedge zclk);
		rst_n <= 1'b1;

		////////////////////////////////////////
		// table rows
		////////////////////////////////////////
		for (i = 0; i < num_rows; i++)
		begin
			row = table_rows[i];
			case (row.kind)
				op_read:
				begin
					@(posedge zclk);
					if (row.rnd)
					begin
						rnd_word  = $urandom();
						cur_lines = rnd_word[18:0];
						lines     <= cur_lines;
					end
					io  <= '{addr: row.addr, din: 8'h00, iorq_n: 1'b0, rd_n: 1'b0, wr_n: 1'b1};
					dos <= row.dos;
					exp_dout = row.rnd ? expected_dout(row.addr[7:0], row.dos, cur_lines) :
						row.exp[7:0];
					@(negedge zclk);
					check_value("dout", 16'(dout), 16'(exp_dout));
					check_value("porthit", 16'(porthit), 16'(row.exp[8]));
					check_value("dataout", 16'(dataout), 16'(row.exp[9]));
					check_value("ay_bc1", 16'(ay_bc1), 16'(row.exp[10]));
					check_value("ay_bdir", 16'(ay_bdir), 16'(row.exp[11]));
					@(posedge zclk);
					io <= io_idle;
				end
				op_write:
				begin
					@(posedge zclk);
					wr_data = row.data;
					if (row.rnd)
					begin
						rnd_word = $urandom();
						wr_data  = rnd_word[7:0];
					end
					last_data = wr_data;
					io  <= '{addr: row.addr, din: wr_data, iorq_n: 1'b0, rd_n: 1'b1, wr_n: 1'b0};
					dos <= row.dos;
					strobe_count = 0;
					for (c = 0; c < 3; c++)   // access held three cycles
					begin
						@(negedge zclk);
						if (dut_i.port_wr)
							strobe_count++;
						if (row.tgt == t_ay)
							check_value(signal_name(t_ay), observe(t_ay), row.exp);
						@(posedge zclk);
					end
					io <= io_idle;
					assert (strobe_count == 1)
					else
						abort_run($sformatf("write strobe for address %h came %0d times, not once",
							row.addr, strobe_count));
				end
				default:
				begin
					@(negedge zclk);
					check_value(signal_name(row.tgt), observe(row.tgt),
						row.rnd ? ({8'h00, last_data} & row.exp) : row.exp);
				end
			endcase
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+tb
hdl/port_map_pkg.sv
hdl/zx_types_pkg.sv
hdl/io_strobe.sv
hdl/port_decode.sv
hdl/paging_regs.sv
hdl/xt_regs.sv
hdl/zports_top.sv
tb/tb_zports.sv
